/* unpack_pkg.sv */
`default_nettype none

package unpack_pkg;

   // stream widths
   localparam int PACKED_W = 32;
   localparam int FIELD_W  = 16;

   // bit fifo holds two of the wider of the two widths
   localparam int BFIFO_W = 2 * ((PACKED_W > FIELD_W) ? PACKED_W : FIELD_W);

   // word fifo entries, equal to the credits upstream holds after reset
   localparam int IN_DEPTH  = 4;
   localparam int OUT_DEPTH = 4;

   typedef logic [PACKED_W-1:0] packed_word_t;

   // right aligned, unused upper bits are zero
   typedef logic [FIELD_W-1:0] field_t;

   // 0 .. FIELD_W
   typedef logic [$clog2(FIELD_W):0] field_len_t;

   // 0 .. BFIFO_W
   typedef logic [$clog2(BFIFO_W):0] bit_level_t;

   typedef logic [$clog2(OUT_DEPTH):0] credit_cnt_t;

   // len must lie in 1 .. FIELD_W
   typedef struct packed {
      field_len_t len;
      logic       wrap;
   } unpack_cfg_s;

endpackage

`default_nettype wire

/* unpack_in_port.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_in_port
   import unpack_pkg::*;
(
   input  wire logic         clk_i,
   input  wire logic         rst_n_i,
   input  wire logic         in_valid_i,
   input  wire packed_word_t in_data_i,
   input  wire logic         word_take_i,
   output logic              in_credit_o,
   output logic              word_avail_o,
   output packed_word_t      word_o
);

   packed_word_t                mem [IN_DEPTH];
   logic [$clog2(IN_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(IN_DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(IN_DEPTH):0]   count_q;
   logic                        rd_en;

   // the sender only sends while holding a credit, so no full check here
   assign rd_en        = word_take_i & word_avail_o;
   assign word_avail_o = (count_q != '0);
   assign word_o       = mem[rd_ptr_q];

   // one credit back for every word handed to the engine
   assign in_credit_o = rd_en;

   always_ff @(posedge clk_i) begin
      if (in_valid_i) begin
         mem[wr_ptr_q] <= in_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (in_valid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({in_valid_i, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* unpack_bfifo.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_bfifo
   import unpack_pkg::*;
(
   input  wire logic         clk_i,
   input  wire logic         rst_n_i,
   input  wire logic         push_i,
   input  wire packed_word_t push_data_i,
   input  wire logic         pop_i,
   input  wire field_len_t   pop_len_i,
   output field_t            pop_data_o,
   output bit_level_t        fill_o,
   output bit_level_t        space_o
);

   logic [BFIFO_W-1:0] data_q;
   bit_level_t         fill_q;
   logic [BFIFO_W-1:0] push_ext;
   field_t             len_onehot;
   field_t             len_mask;

   // bits above the fill level are kept at zero, so a push can OR in
   assign push_ext = {{(BFIFO_W - PACKED_W){1'b0}}, push_data_i};

   // mask of pop_len_i ones, 16 gives all ones
   assign len_onehot = field_t'(1'b1) << pop_len_i;
   assign len_mask   = len_onehot - 1'b1;

   assign pop_data_o = data_q[FIELD_W-1:0] & len_mask;
   assign fill_o     = fill_q;
   assign space_o    = bit_level_t'(BFIFO_W) - fill_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         data_q <= '0;
         fill_q <= '0;
      end else if (push_i) begin
         // new word lands right above the current fill
         data_q <= data_q | (push_ext << fill_q);
         fill_q <= fill_q + bit_level_t'(PACKED_W);
      end else if (pop_i) begin
         // oldest bits leave from the bottom, zeros shift in at the top
         data_q <= data_q >> pop_len_i;
         fill_q <= fill_q - bit_level_t'(pop_len_i);
      end
   end

endmodule

`default_nettype wire

/* unpack_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_engine
   import unpack_pkg::*;
(
   input  wire logic         clk_i,
   input  wire logic         rst_n_i,
   input  wire unpack_cfg_s  cfg_i,
   input  wire logic         word_avail_i,
   input  wire packed_word_t word_i,
   input  wire logic         field_ready_i,
   output logic              word_take_o,
   output logic              field_wr_o,
   output field_t            field_o
);

   localparam int ACC_W = $clog2(PACKED_W);

   // holding register for the next word to push
   packed_word_t     hold_word_q;
   logic             held_q;
   logic             held_nxt;

   logic             push;
   logic             pop;
   field_len_t       pop_len;
   bit_level_t       fill;
   bit_level_t       space;

   // bit position inside the current word
   logic [ACC_W-1:0] acc_q;
   logic [ACC_W-1:0] acc_nxt;
   logic [ACC_W:0]   acc_sum;
   logic [ACC_W-1:0] wrap_rem;
   logic             wrap_now;

   assign acc_sum  = {1'b0, acc_q} + (ACC_W + 1)'(cfg_i.len);
   assign wrap_rem = ACC_W'(PACKED_W) - acc_q;
   // next field would cross the word boundary
   assign wrap_now = cfg_i.wrap & (acc_sum > (ACC_W + 1)'(PACKED_W));

   always_comb begin
      pop         = 1'b0;
      pop_len     = cfg_i.len;
      push        = 1'b0;
      word_take_o = 1'b0;
      field_wr_o  = 1'b0;
      held_nxt    = held_q;
      acc_nxt     = acc_q;
      if (wrap_now) begin
         // drop the leftover high bits of the word, nothing written
         pop     = 1'b1;
         pop_len = field_len_t'(wrap_rem);
         acc_nxt = '0;
      end else if ((fill >= bit_level_t'(cfg_i.len)) && field_ready_i) begin
         pop        = 1'b1;
         field_wr_o = 1'b1;
         // wraps to zero at an exact word boundary
         acc_nxt    = acc_sum[ACC_W-1:0];
      end else if (held_q && (space >= bit_level_t'(PACKED_W))) begin
         push = 1'b1;
         if (word_avail_i) begin
            word_take_o = 1'b1;
         end else begin
            held_nxt = 1'b0;
         end
      end else if (!held_q && word_avail_i) begin
         word_take_o = 1'b1;
         held_nxt    = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (word_take_o) begin
         hold_word_q <= word_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         held_q <= 1'b0;
         acc_q  <= '0;
      end else begin
         held_q <= held_nxt;
         acc_q  <= acc_nxt;
      end
   end

   unpack_bfifo u_bfifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .push_data_i (hold_word_q),
      .pop_i       (pop),
      .pop_len_i   (pop_len),
      .pop_data_o  (field_o),
      .fill_o      (fill),
      .space_o     (space)
   );

endmodule

`default_nettype wire

/* unpack_out_port.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_out_port
   import unpack_pkg::*;
(
   input  wire logic   clk_i,
   input  wire logic   rst_n_i,
   input  wire logic   field_wr_i,
   input  wire field_t field_i,
   input  wire logic   out_credit_i,
   output logic        field_ready_o,
   output logic        out_valid_o,
   output field_t      out_data_o
);

   field_t                       mem [OUT_DEPTH];
   logic [$clog2(OUT_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(OUT_DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(OUT_DEPTH):0]   fill_q;
   credit_cnt_t                  credit_cnt_q;
   logic                         beat;

   assign field_ready_o = (fill_q != OUT_DEPTH[$clog2(OUT_DEPTH):0]);

   // a beat needs both a stored field and a downstream credit
   assign beat = (fill_q != '0) && (credit_cnt_q != '0);

   always_ff @(posedge clk_i) begin
      if (field_wr_i) begin
         mem[wr_ptr_q] <= field_i;
      end
      if (beat) begin
         out_data_o <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         fill_q       <= '0;
         credit_cnt_q <= '0;
         out_valid_o  <= 1'b0;
      end else begin
         out_valid_o <= beat;
         if (field_wr_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (beat) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({field_wr_i, beat})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase
         // credit in and beat out in one cycle cancel
         case ({out_credit_i, beat})
            2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
            2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
            default: credit_cnt_q <= credit_cnt_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* unpack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_top
   import unpack_pkg::*;
(
   input  wire logic         clk_i,
   input  wire logic         rst_n_i,
   input  wire unpack_cfg_s  cfg_i,
   input  wire logic         in_valid_i,
   input  wire packed_word_t in_data_i,
   output logic              in_credit_o,
   input  wire logic         out_credit_i,
   output logic              out_valid_o,
   output field_t            out_data_o
);

   // input port to engine
   logic         word_avail;
   packed_word_t word;
   logic         word_take;

   // engine to output port
   logic         field_wr;
   field_t       field;
   logic         field_ready;

   unpack_in_port u_in_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .in_data_i    (in_data_i),
      .word_take_i  (word_take),
      .in_credit_o  (in_credit_o),
      .word_avail_o (word_avail),
      .word_o       (word)
   );

   unpack_engine u_engine (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cfg_i         (cfg_i),
      .word_avail_i  (word_avail),
      .word_i        (word),
      .field_ready_i (field_ready),
      .word_take_o   (word_take),
      .field_wr_o    (field_wr),
      .field_o       (field)
   );

   unpack_out_port u_out_port (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .field_wr_i    (field_wr),
      .field_i       (field),
      .out_credit_i  (out_credit_i),
      .field_ready_o (field_ready),
      .out_valid_o   (out_valid_o),
      .out_data_o    (out_data_o)
   );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o
);

   // 4 ns period
   localparam int HALF_PERIOD_NS = 2;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD_NS clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

/* tb_unpack_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_unpack_checker
   import unpack_pkg::*;
(
   input wire logic   clk_i,
   input wire logic   rst_n_i,
   input wire logic   in_credit_i,
   input wire logic   out_valid_i,
   input wire field_t out_data_i
);

   field_t exp_q[$];
   field_t exp_field;
   string  test_name;
   int     test_errs;
   int     field_cnt;
   int     credit_cnt;
   int     pass_cnt = 0;
   int     fail_cnt = 0;

   task automatic start_test(input string name);
      test_name  = name;
      test_errs  = 0;
      field_cnt  = 0;
      credit_cnt = 0;
      exp_q.delete();
   endtask

   task automatic expect_field(input field_t value);
      exp_q.push_back(value);
   endtask

   function automatic int remaining();
      return exp_q.size();
   endfunction

   always @(posedge clk_i) begin
      if (rst_n_i) begin
         if (in_credit_i) begin
            credit_cnt++;
         end
         if (out_valid_i) begin
            if (exp_q.size() == 0) begin
               $display("%s: field 0x%h arrived with no field expected", test_name, out_data_i);
               test_errs++;
            end else begin
               exp_field = exp_q.pop_front();
               if (out_data_i !== exp_field) begin
                  $display("MISMATCH out_data_o expected 0x%h received 0x%h (field %0d of %s)",
                           exp_field, out_data_i, field_cnt, test_name);
                  test_errs++;
               end
               field_cnt++;
            end
         end
      end
   end

   task automatic end_test(input int words_sent);
      if (exp_q.size() != 0) begin
         $display("%s: %0d expected fields never arrived", test_name, exp_q.size());
         test_errs++;
      end
      if (credit_cnt != words_sent) begin
         $display("%s: %0d input credits came back for %0d words sent",
                  test_name, credit_cnt, words_sent);
         test_errs++;
      end
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s: pass (%0d fields)", test_name, field_cnt);
      end else begin
         fail_cnt++;
         $display("test %s: fail (%0d errors)", test_name, test_errs);
      end
   endtask

   task automatic report_counts(input int assert_errs);
      $display("tests passed %0d, failed %0d, assertion errors %0d",
               pass_cnt, fail_cnt, assert_errs);
   endtask

endmodule

`default_nettype wire

/* tb_unpack_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_unpack_assertions
   import unpack_pkg::*;
(
   input wire logic        clk_i,
   input wire logic        rst_n_i,
   input wire logic        field_wr_i,
   input wire logic        field_ready_i,
   input wire credit_cnt_t credit_cnt_i,
   input wire logic        out_valid_i
);

   int err_cnt = 0;

   // a beat is only launched with a credit in hand
   valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (credit_cnt_i == '0) |=> !out_valid_i)
      else begin
         err_cnt++;
         $error("out_valid_o raised with no output credit");
      end

   no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      field_wr_i |-> field_ready_i)
      else begin
         err_cnt++;
         $error("field FIFO written while full");
      end

   quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
      else begin
         err_cnt++;
         $error("out_valid_o high during reset");
      end

endmodule

`default_nettype wire

/* tb_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_unpack
   import unpack_pkg::*;
();

   localparam int WORDS_T1        = 40;
   localparam int WORDS_T2        = 40;
   localparam int WORDS_T3        = 40;
   localparam int WORDS_T4        = 60;
   localparam int WORDS_T5        = 20;
   localparam int MAX_OUT_CREDITS = 4;
   localparam int TIMEOUT_CYCLES  =
      (WORDS_T1 + WORDS_T2 + WORDS_T3 + WORDS_T4 + 2 * WORDS_T5) * 40 + 200;

   logic         clk;
   logic         rst_n;
   unpack_cfg_s  cfg;
   logic         in_valid;
   packed_word_t in_data;
   logic         in_credit;
   logic         out_credit;
   logic         out_valid;
   field_t       out_data;

   int           seed = 75;
   int           cycle_cnt = 0;
   packed_word_t stim_words[$];
   bit           model_bits[$];

   tb_clk_gen u_clk_gen (.clk_o (clk));

   unpack_top UUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .cfg_i        (cfg),
      .in_valid_i   (in_valid),
      .in_data_i    (in_data),
      .in_credit_o  (in_credit),
      .out_credit_i (out_credit),
      .out_valid_o  (out_valid),
      .out_data_o   (out_data)
   );

   tb_unpack_checker u_checker (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .in_credit_i (in_credit),
      .out_valid_i (out_valid),
      .out_data_i  (out_data)
   );

   bind unpack_out_port tb_unpack_assertions u_assertions (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .field_wr_i    (field_wr_i),
      .field_ready_i (field_ready_o),
      .credit_cnt_i  (credit_cnt_q),
      .out_valid_i   (out_valid_o)
   );

   function automatic field_t cut_field(input int pos, input int len);
      field_t fld;
      int     k;
      fld = '0;
      for (k = 0; k < len; k++) begin
         fld[k] = model_bits[pos + k];
      end
      return fld;
   endfunction

   task automatic build_model(input int len, input bit wrap);
      int w;
      int b;
      int f;
      int pos;
      model_bits.delete();
      for (w = 0; w < stim_words.size(); w++) begin
         for (b = 0; b < PACKED_W; b++) begin
            model_bits.push_back(stim_words[w][b]);
         end
      end
      if (wrap) begin
         // whole fields from bit 0 of each word, the rest of the word is dropped
         for (w = 0; w < stim_words.size(); w++) begin
            for (f = 0; f < PACKED_W / len; f++) begin
               u_checker.expect_field(cut_field(w * PACKED_W + f * len, len));
            end
         end
      end else begin
         // a tail too short for a field stays unchecked
         for (pos = 0; pos + len <= model_bits.size(); pos += len) begin
            u_checker.expect_field(cut_field(pos, len));
         end
      end
   endtask

   task automatic run_test(input string name, input int len, input bit wrap,
                           input int nwords, input int rate);
      int up_credits;
      int outstanding;
      int sent;
      int w;
      bit finished;
      @(posedge clk);
      rst_n      <= 1'b0;
      in_valid   <= 1'b0;
      out_credit <= 1'b0;
      cfg.len    <= field_len_t'(len);
      cfg.wrap   <= wrap;
      stim_words.delete();
      for (w = 0; w < nwords; w++) begin
         stim_words.push_back($random(seed));
      end
      u_checker.start_test(name);
      build_model(len, wrap);
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      up_credits  = IN_DEPTH;
      outstanding = 0;
      sent        = 0;
      finished    = 1'b0;
      while (!finished) begin
         @(posedge clk);
         if ((up_credits > 0) && (sent < nwords)) begin
            in_valid <= 1'b1;
            in_data  <= stim_words[sent];
            sent++;
            up_credits--;
         end else begin
            in_valid <= 1'b0;
         end
         if ((outstanding < MAX_OUT_CREDITS) && (({$random(seed)} % 100) < rate)) begin
            out_credit <= 1'b1;
            outstanding++;
         end else begin
            out_credit <= 1'b0;
         end
         // outputs are settled half a cycle after the edge
         @(negedge clk);
         if (in_credit) begin
            up_credits++;
         end
         if (out_valid) begin
            outstanding--;
         end
         finished = (sent == nwords) && (u_checker.remaining() == 0);
      end
      @(posedge clk);
      in_valid   <= 1'b0;
      out_credit <= 1'b0;
      repeat (8) @(posedge clk);
      u_checker.end_test(sent);
   endtask

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      rst_n      = 1'b0;
      cfg        = '0;
      in_valid   = 1'b0;
      in_data    = '0;
      out_credit = 1'b0;
      run_test("cont_len8", 8, 1'b0, WORDS_T1, 100);
      run_test("cont_len5", 5, 1'b0, WORDS_T2, 40 + ({$random(seed)} % 60));
      run_test("wrap_len5", 5, 1'b1, WORDS_T3, 40 + ({$random(seed)} % 60));
      run_test("cont_len16_sparse", 16, 1'b0, WORDS_T4, 10 + ({$random(seed)} % 20));
      run_test("wrap_len1", 1, 1'b1, WORDS_T5, 100);
      run_test("wrap_len16", 16, 1'b1, WORDS_T5, 100);
      u_checker.report_counts(UUT.u_out_port.u_assertions.err_cnt);
      if ((u_checker.fail_cnt == 0) && (UUT.u_out_port.u_assertions.err_cnt == 0)) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
unpack_pkg.sv
unpack_in_port.sv
unpack_bfifo.sv
unpack_engine.sv
unpack_out_port.sv
unpack_top.sv
tb_clk_gen.sv
tb_unpack_checker.sv
tb_unpack_assertions.sv
tb_unpack.sv

/* Bender.yml */
package:
  name: unpack

sources:
  - unpack_pkg.sv
  - unpack_in_port.sv
  - unpack_bfifo.sv
  - unpack_engine.sv
  - unpack_out_port.sv
  - unpack_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_unpack_checker.sv
      - tb_unpack_assertions.sv
      - tb_unpack.sv
